// File: logic/dl_rx_frame.sv
`include "dl_rx_params.svh"

module dl_rx_frame (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  dl_rx_pkg::dl_word_t   rx_data_i,
  input  logic                  rx_valid_i,
  input  logic                  rx_last_i,
  output logic                  rx_ready_o,
  output logic                  crc_clear_o,
  output logic                  crc_update_o,
  output dl_rx_pkg::dl_word_t   crc_word_o,
  input  dl_rx_pkg::dl_word_t   crc_value_i,
  input  logic                  buf_full_i,
  output logic                  wr_en_o,
  output dl_rx_pkg::tlp_len_t   wr_addr_o,
  output dl_rx_pkg::dl_word_t   wr_data_o,
  output logic                  commit_o,
  output dl_rx_pkg::tlp_len_t   commit_len_o,
  output logic                  ack_req_o,
  output dl_rx_pkg::dllp_kind_e ack_kind_o,
  output dl_rx_pkg::seq_num_t   ack_seq_o,
  output dl_rx_pkg::tlp_class_e ack_class_o,
  output dl_rx_pkg::tlp_len_t   ack_len_o,
  input  logic                  ack_done_i
);
  import dl_rx_pkg::*;

  frame_st_e  state_r;
  seq_num_t   exp_seq_r;
  tlp_len_t   cnt_r;
  logic       hold_valid_r;
  logic       len_err_r;
  dl_word_t   hold_word_r;
  seq_num_t   rx_seq_r;
  tlp_class_e cls_r;
  dllp_kind_e kind_r;
  seq_num_t   ack_seq_r;
  tlp_len_t   ack_len_r;

  logic     accept;
  logic     room;
  seq_num_t seq_diff;
  logic     crc_ok;
  logic     len_ok;
  logic     in_order;
  logic     dup;

  // type byte 3 of the first header word
  function automatic tlp_class_e classify(logic [7:0] fmt_type);
    case (fmt_type)
      8'h40, 8'h60: return TLP_POSTED;
      8'h0A, 8'h4A: return TLP_CPL;
      default: return TLP_NONPOSTED;
    endcase
  endfunction

  assign rx_ready_o = (state_r == FR_SEQ) || (state_r == FR_BODY);
  assign accept = rx_valid_i && rx_ready_o;
  assign room = (cnt_r != tlp_len_t'(`DL_MAX_TLP_DW));

  // lcrc covers the seq word, then each word once it is known not to be the last
  assign crc_clear_o = (state_r == FR_IDLE) || (state_r == FR_SEQ);
  assign crc_update_o = accept && ((state_r == FR_SEQ) || hold_valid_r);
  assign crc_word_o = (state_r == FR_SEQ) ? rx_data_i : hold_word_r;

  assign wr_en_o = accept && (state_r == FR_BODY) && hold_valid_r && room;
  assign wr_addr_o = cnt_r;
  assign wr_data_o = hold_word_r;

  // hold_word_r holds the received lcrc at the verdict
  assign seq_diff = exp_seq_r - rx_seq_r;
  assign crc_ok = (crc_value_i == hold_word_r);
  assign len_ok = !len_err_r && (cnt_r >= tlp_len_t'(`DL_HDR_DW));
  assign in_order = (seq_diff == '0);
  // behind expected by less than half the space means a replay
  assign dup = !in_order && !seq_diff[`DL_SEQ_W-1];

  assign commit_o = (state_r == FR_VERDICT) && crc_ok && len_ok && in_order;
  assign commit_len_o = cnt_r;

  assign ack_req_o = (state_r == FR_WAIT_ACK);
  assign ack_kind_o = kind_r;
  assign ack_seq_o = ack_seq_r;
  assign ack_class_o = cls_r;
  assign ack_len_o = ack_len_r;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r <= FR_IDLE;
      exp_seq_r <= '0;
      cnt_r <= '0;
      hold_valid_r <= 1'b0;
      len_err_r <= 1'b0;
    end else begin
      case (state_r)
        FR_IDLE: begin
          if (!buf_full_i) begin
            state_r <= FR_SEQ;
          end
        end
        FR_SEQ: begin
          if (accept) begin
            cnt_r <= '0;
            hold_valid_r <= 1'b0;
            // tlast on the seq word is a malformed frame
            len_err_r <= rx_last_i;
            state_r <= rx_last_i ? FR_VERDICT : FR_BODY;
          end
        end
        FR_BODY: begin
          if (accept) begin
            hold_valid_r <= 1'b1;
            if (hold_valid_r && room) begin
              cnt_r <= cnt_r + 1'b1;
            end else if (hold_valid_r) begin
              len_err_r <= 1'b1;
            end
            if (rx_last_i) begin
              state_r <= FR_VERDICT;
            end
          end
        end
        FR_VERDICT: begin
          if (commit_o) begin
            exp_seq_r <= exp_seq_r + 1'b1;
          end
          state_r <= FR_WAIT_ACK;
        end
        FR_WAIT_ACK: begin
          if (ack_done_i) begin
            state_r <= FR_IDLE;
          end
        end
        default: state_r <= FR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_word_r <= rx_data_i;
    end
    if (accept && (state_r == FR_SEQ)) begin
      rx_seq_r <= rx_data_i[`DL_SEQ_W-1:0];
    end
    if (wr_en_o && (cnt_r == '0)) begin
      cls_r <= classify(hold_word_r[31:24]);
    end
    if (state_r == FR_VERDICT) begin
      // length 0 tells the dllp side nothing was stored
      if (commit_o) begin
        kind_r <= DLLP_ACK;
        ack_seq_r <= rx_seq_r;
        ack_len_r <= cnt_r;
      end else begin
        kind_r <= (crc_ok && len_ok && dup) ? DLLP_ACK : DLLP_NAK;
        ack_seq_r <= exp_seq_r - 1'b1;
        ack_len_r <= '0;
      end
    end
  end

  // the buffer only fills through our own commit, so it stays open for the frame
  a_no_write_full: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_o |-> !buf_full_i);

  // the dllp side only finishes a request that is still pending
  a_done_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_done_i |-> ack_req_o);

endmodule

// File: logic/dl_rx_params.svh
`ifndef DL_RX_PARAMS_SVH
`define DL_RX_PARAMS_SVH

// stream and frame geometry
`define DL_WORD_W      32
`define DL_SEQ_W       12
`define DL_MAX_TLP_DW  16
`define DL_HDR_DW      4
`define DL_SLOTS       2

// flow control credit widths
`define DL_HDR_CRED_W  8
`define DL_DATA_CRED_W 12

`define DL_LCRC_POLY   32'h04C11DB7

// dllp type bytes
`define DL_DLLP_ACK    8'h00
`define DL_DLLP_NAK    8'h10
`define DL_DLLP_FC_P   8'h80
`define DL_DLLP_FC_NP  8'h90

`endif

// File: logic/dl_rx_pkg.sv
`include "dl_rx_params.svh"

package dl_rx_pkg;

  typedef logic [`DL_WORD_W-1:0] dl_word_t;
  typedef logic [`DL_SEQ_W-1:0] seq_num_t;

  // word count 0..DL_MAX_TLP_DW, also used as word offset in a slot
  typedef logic [$clog2(`DL_MAX_TLP_DW):0] tlp_len_t;

  // slot pointer with wrap bit on top
  typedef logic [$clog2(`DL_SLOTS):0] slot_idx_t;

  typedef logic [`DL_HDR_CRED_W-1:0] hdr_cred_t;
  typedef logic [`DL_DATA_CRED_W-1:0] data_cred_t;

  typedef enum logic [1:0] {
    TLP_POSTED,
    TLP_NONPOSTED,
    TLP_CPL
  } tlp_class_e;

  typedef enum logic {
    DLLP_ACK,
    DLLP_NAK
  } dllp_kind_e;

  typedef enum logic [2:0] {
    FR_IDLE,
    FR_SEQ,
    FR_BODY,
    FR_VERDICT,
    FR_WAIT_ACK
  } frame_st_e;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_FETCH,
    OUT_STREAM
  } out_st_e;

endpackage

// File: logic/dl_rx_top.sv
module dl_rx_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dl_rx_pkg::dl_word_t rx_data_i,
  input  logic                rx_valid_i,
  input  logic                rx_last_i,
  output logic                rx_ready_o,
  output dl_rx_pkg::dl_word_t tlp_data_o,
  output logic                tlp_valid_o,
  output logic                tlp_last_o,
  input  logic                tlp_ready_i,
  output dl_rx_pkg::dl_word_t dllp_data_o,
  output logic                dllp_valid_o,
  input  logic                dllp_ready_i
);
  import dl_rx_pkg::*;

  // lcrc
  logic       crc_clear;
  logic       crc_update;
  dl_word_t   crc_word;
  dl_word_t   crc_value;

  // slot buffer
  logic       buf_full;
  logic       buf_empty;
  logic       wr_en;
  tlp_len_t   wr_addr;
  dl_word_t   wr_data;
  logic       commit;
  tlp_len_t   commit_len;
  tlp_len_t   rd_addr;
  dl_word_t   rd_data;
  logic       buf_release;
  tlp_len_t   head_len;

  // dllp request
  logic       ack_req;
  dllp_kind_e ack_kind;
  seq_num_t   ack_seq;
  tlp_class_e ack_class;
  tlp_len_t   ack_len;
  logic       ack_done;

  dl_rx_frame dl_rx_frame_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_data_i    (rx_data_i),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_ready_o   (rx_ready_o),
    .crc_clear_o  (crc_clear),
    .crc_update_o (crc_update),
    .crc_word_o   (crc_word),
    .crc_value_i  (crc_value),
    .buf_full_i   (buf_full),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .commit_o     (commit),
    .commit_len_o (commit_len),
    .ack_req_o    (ack_req),
    .ack_kind_o   (ack_kind),
    .ack_seq_o    (ack_seq),
    .ack_class_o  (ack_class),
    .ack_len_o    (ack_len),
    .ack_done_i   (ack_done)
  );

  lcrc_accum lcrc_accum_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .crc_clear_i  (crc_clear),
    .crc_update_i (crc_update),
    .crc_word_i   (crc_word),
    .crc_value_o  (crc_value)
  );

  tlp_slot_buffer tlp_slot_buffer_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .commit_i     (commit),
    .commit_len_i (commit_len),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .release_i    (buf_release),
    .head_len_o   (head_len),
    .full_o       (buf_full),
    .empty_o      (buf_empty)
  );

  tlp_out_stream tlp_out_stream_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .empty_i      (buf_empty),
    .head_len_i   (head_len),
    .rd_addr_o    (rd_addr),
    .rd_data_i    (rd_data),
    .release_o    (buf_release),
    .tlp_data_o   (tlp_data_o),
    .tlp_valid_o  (tlp_valid_o),
    .tlp_last_o   (tlp_last_o),
    .tlp_ready_i  (tlp_ready_i)
  );

  dllp_tx_gen dllp_tx_gen_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ack_req_i    (ack_req),
    .ack_kind_i   (ack_kind),
    .ack_seq_i    (ack_seq),
    .ack_class_i  (ack_class),
    .ack_len_i    (ack_len),
    .ack_done_o   (ack_done),
    .dllp_data_o  (dllp_data_o),
    .dllp_valid_o (dllp_valid_o),
    .dllp_ready_i (dllp_ready_i)
  );

endmodule

// File: logic/dllp_tx_gen.sv
`include "dl_rx_params.svh"

module dllp_tx_gen (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ack_req_i,
  input  dl_rx_pkg::dllp_kind_e ack_kind_i,
  input  dl_rx_pkg::seq_num_t   ack_seq_i,
  input  dl_rx_pkg::tlp_class_e ack_class_i,
  input  dl_rx_pkg::tlp_len_t   ack_len_i,
  output logic                  ack_done_o,
  output dl_rx_pkg::dl_word_t   dllp_data_o,
  output logic                  dllp_valid_o,
  input  logic                  dllp_ready_i
);
  import dl_rx_pkg::*;

  hdr_cred_t  ph_tot_r;
  hdr_cred_t  nph_tot_r;
  data_cred_t pd_tot_r;
  data_cred_t npd_tot_r;
  logic       fc_pend_r;

  logic       fire;
  logic       posted;
  logic       fc_due;
  data_cred_t data_inc;
  hdr_cred_t  hdr_next;
  data_cred_t data_next;
  dl_word_t   ack_word;
  dl_word_t   fc_word;

  assign fire = dllp_valid_o && dllp_ready_i;
  // the request is released after the last dllp of the frame goes out
  assign ack_done_o = fire && !fc_pend_r;

  // zero length means nothing was stored for this ack
  assign fc_due = (ack_kind_i == DLLP_ACK) && (ack_len_i != '0) && (ack_class_i != TLP_CPL);
  assign posted = (ack_class_i == TLP_POSTED);

  // payload words rounded up to 4 dw credits
  assign data_inc = data_cred_t'((ack_len_i - tlp_len_t'(`DL_HDR_DW) + tlp_len_t'(3)) >> 2);
  assign hdr_next = (posted ? ph_tot_r : nph_tot_r) + 1'b1;
  assign data_next = (posted ? pd_tot_r : npd_tot_r) + data_inc;

  assign ack_word = {(ack_kind_i == DLLP_ACK) ? `DL_DLLP_ACK : `DL_DLLP_NAK, 12'h000, ack_seq_i};
  assign fc_word = {posted ? `DL_DLLP_FC_P : `DL_DLLP_FC_NP, 2'b00, hdr_next, 2'b00, data_next};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      dllp_valid_o <= 1'b0;
      fc_pend_r <= 1'b0;
      ph_tot_r <= '0;
      nph_tot_r <= '0;
      pd_tot_r <= '0;
      npd_tot_r <= '0;
    end else if (!dllp_valid_o) begin
      if (ack_req_i) begin
        dllp_valid_o <= 1'b1;
        fc_pend_r <= fc_due;
      end
    end else if (fire) begin
      if (fc_pend_r) begin
        // ack taken, totals move and the updatefc goes out next
        fc_pend_r <= 1'b0;
        if (posted) begin
          ph_tot_r <= hdr_next;
          pd_tot_r <= data_next;
        end else begin
          nph_tot_r <= hdr_next;
          npd_tot_r <= data_next;
        end
      end else begin
        dllp_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dllp_valid_o && ack_req_i) begin
      dllp_data_o <= ack_word;
    end else if (fire && fc_pend_r) begin
      dllp_data_o <= fc_word;
    end
  end

  a_dllp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    dllp_valid_o && !dllp_ready_i |=> dllp_valid_o && $stable(dllp_data_o));

endmodule

// File: logic/lcrc_accum.sv
`include "dl_rx_params.svh"

module lcrc_accum (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                crc_clear_i,
  input  logic                crc_update_i,
  input  dl_rx_pkg::dl_word_t crc_word_i,
  output dl_rx_pkg::dl_word_t crc_value_o
);
  import dl_rx_pkg::*;

  dl_word_t crc_r;
  dl_word_t crc_base;

  // msb first, no reflection
  function automatic dl_word_t crc_fold(dl_word_t crc, dl_word_t word);
    dl_word_t c;
    c = crc;
    for (int i = `DL_WORD_W - 1; i >= 0; i--) begin
      if (c[`DL_WORD_W-1] ^ word[i]) begin
        c = (c << 1) ^ `DL_LCRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  // clear with update starts a new frame with this word folded in
  assign crc_base = crc_clear_i ? '1 : crc_r;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      crc_r <= '1;
    end else if (crc_update_i) begin
      crc_r <= crc_fold(crc_base, crc_word_i);
    end else if (crc_clear_i) begin
      crc_r <= '1;
    end
  end

  assign crc_value_o = ~crc_r;

endmodule

// File: logic/tlp_out_stream.sv
module tlp_out_stream (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                empty_i,
  input  dl_rx_pkg::tlp_len_t head_len_i,
  output dl_rx_pkg::tlp_len_t rd_addr_o,
  input  dl_rx_pkg::dl_word_t rd_data_i,
  output logic                release_o,
  output dl_rx_pkg::dl_word_t tlp_data_o,
  output logic                tlp_valid_o,
  output logic                tlp_last_o,
  input  logic                tlp_ready_i
);
  import dl_rx_pkg::*;

  out_st_e  state_r;
  tlp_len_t idx_r;
  tlp_len_t last_idx;
  logic     fire;

  assign fire = tlp_valid_o && tlp_ready_i;
  assign last_idx = head_len_i - 1'b1;
  assign release_o = (state_r == OUT_STREAM) && fire && tlp_last_o;

  // idx_r is the word waiting on rd_data, move on once the output takes one
  always_comb begin
    case (state_r)
      OUT_FETCH: rd_addr_o = tlp_len_t'(1);
      OUT_STREAM: rd_addr_o = fire ? idx_r + 1'b1 : idx_r;
      default: rd_addr_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r <= OUT_IDLE;
      idx_r <= '0;
      tlp_valid_o <= 1'b0;
      tlp_last_o <= 1'b0;
    end else begin
      case (state_r)
        OUT_IDLE: begin
          if (!empty_i) begin
            state_r <= OUT_FETCH;
          end
        end
        OUT_FETCH: begin
          tlp_valid_o <= 1'b1;
          tlp_last_o <= (last_idx == '0);
          idx_r <= tlp_len_t'(1);
          state_r <= OUT_STREAM;
        end
        OUT_STREAM: begin
          if (fire && tlp_last_o) begin
            tlp_valid_o <= 1'b0;
            tlp_last_o <= 1'b0;
            state_r <= OUT_IDLE;
          end else if (fire) begin
            tlp_last_o <= (idx_r == last_idx);
            idx_r <= idx_r + 1'b1;
          end
        end
        default: state_r <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == OUT_FETCH) || ((state_r == OUT_STREAM) && fire && !tlp_last_o)) begin
      tlp_data_o <= rd_data_i;
    end
  end

  a_data_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    tlp_valid_o && !tlp_ready_i |=> tlp_valid_o && $stable(tlp_data_o));

endmodule

// File: logic/tlp_slot_buffer.sv
`include "dl_rx_params.svh"

module tlp_slot_buffer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wr_en_i,
  input  dl_rx_pkg::tlp_len_t wr_addr_i,
  input  dl_rx_pkg::dl_word_t wr_data_i,
  input  logic                commit_i,
  input  dl_rx_pkg::tlp_len_t commit_len_i,
  input  dl_rx_pkg::tlp_len_t rd_addr_i,
  output dl_rx_pkg::dl_word_t rd_data_o,
  input  logic                release_i,
  output dl_rx_pkg::tlp_len_t head_len_o,
  output logic                full_o,
  output logic                empty_o
);
  import dl_rx_pkg::*;

  // slot count is a power of two so the wrap bit falls out of the adder
  localparam int SlotBits = $clog2(`DL_SLOTS);
  localparam int Depth = `DL_SLOTS * `DL_MAX_TLP_DW;
  localparam int MemAw = $clog2(Depth);

  dl_word_t  mem_q [Depth];
  tlp_len_t  len_q [`DL_SLOTS];
  slot_idx_t head_r;
  slot_idx_t tail_r;

  logic [MemAw-1:0] wr_mem_addr;
  logic [MemAw-1:0] rd_mem_addr;

  // slot base plus word offset
  assign wr_mem_addr = MemAw'(tail_r[SlotBits-1:0] * `DL_MAX_TLP_DW) + MemAw'(wr_addr_i);
  assign rd_mem_addr = MemAw'(head_r[SlotBits-1:0] * `DL_MAX_TLP_DW) + MemAw'(rd_addr_i);

  assign empty_o = (head_r == tail_r);
  assign full_o = (head_r[SlotBits] != tail_r[SlotBits]) &&
                  (head_r[SlotBits-1:0] == tail_r[SlotBits-1:0]);
  assign head_len_o = len_q[head_r[SlotBits-1:0]];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      head_r <= '0;
      tail_r <= '0;
    end else begin
      if (commit_i) begin
        tail_r <= tail_r + 1'b1;
      end
      if (release_i) begin
        head_r <= head_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_mem_addr] <= wr_data_i;
    end
    if (commit_i) begin
      len_q[tail_r[SlotBits-1:0]] <= commit_len_i;
    end
    rd_data_o <= mem_q[rd_mem_addr];
  end

  a_ptr_bounds: assert property (@(posedge clk_i) disable iff (rst_i)
    !(commit_i && full_o) && !(release_i && empty_o));

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the dl_rx testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module dl_rx_tb \
  -Mdir obj_dir -o dl_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/dl_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: verification/dl_rx_tb.sv
`include "dl_rx_params.svh"

module dl_rx_tb;
  import dl_rx_pkg::*;

  logic     clk_i;
  logic     rst_i;
  dl_word_t rx_data_i;
  logic     rx_valid_i;
  logic     rx_last_i;
  logic     rx_ready_o;
  dl_word_t tlp_data_o;
  logic     tlp_valid_o;
  logic     tlp_last_o;
  logic     tlp_ready_i;
  dl_word_t dllp_data_o;
  logic     dllp_valid_o;
  logic     dllp_ready_i;

  // frame table, one entry per frame in each queue
  int row_back[$];
  int row_fmt[$];
  int row_len[$];
  int row_bad[$];
  int row_hold[$];
  int row_jit[$];

  dl_word_t frame_q[$];
  dl_word_t want_tlp_q[$];
  logic     want_last_q[$];
  dl_word_t want_dllp_q[$];

  // reference model state
  seq_num_t   exp_seq;
  hdr_cred_t  p_hdr;
  hdr_cred_t  np_hdr;
  data_cred_t p_data;
  data_cred_t np_data;

  logic [31:0] rng;
  int          tlp_hold;
  logic        dllp_jitter;
  int          wd_cycles;

  dl_rx_top dl_rx_top_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_data_i    (rx_data_i),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_ready_o   (rx_ready_o),
    .tlp_data_o   (tlp_data_o),
    .tlp_valid_o  (tlp_valid_o),
    .tlp_last_o   (tlp_last_o),
    .tlp_ready_i  (tlp_ready_i),
    .dllp_data_o  (dllp_data_o),
    .dllp_valid_o (dllp_valid_o),
    .dllp_ready_i (dllp_ready_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // byte at a time, msb first, no reflection
  function automatic dl_word_t crc_word(input dl_word_t crc, input dl_word_t word);
    dl_word_t   c;
    logic [7:0] b;
    c = crc;
    for (int k = 3; k >= 0; k--) begin
      b = word[k*8 +: 8];
      c = c ^ {b, 24'h000000};
      for (int j = 0; j < 8; j++) begin
        c = c[31] ? ((c << 1) ^ `DL_LCRC_POLY) : (c << 1);
      end
    end
    return c;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic add_row(input int back, input int fmt, input int len, input int bad,
                         input int hold, input int jit);
    row_back.push_back(back);
    row_fmt.push_back(fmt);
    row_len.push_back(len);
    row_bad.push_back(bad);
    row_hold.push_back(hold);
    row_jit.push_back(jit);
  endtask

  task automatic build_table();
    // back  fmt    len bad hold jitter
    add_row(0, 8'h40, 4,  0, 0,  0);
    add_row(0, 8'h00, 7,  0, 0,  0);
    add_row(0, 8'h4A, 16, 0, 0,  0);
    add_row(0, 8'h60, 8,  1, 0,  0);
    // replay of the last stored frame
    add_row(1, 8'h40, 6,  0, 0,  0);
    add_row(0, 8'h20, 5,  0, 0,  1);
    // output held long enough to fill both slots
    add_row(0, 8'h40, 16, 0, 80, 1);
    add_row(0, 8'h0A, 9,  0, 0,  0);
    add_row(0, 8'h44, 12, 0, 0,  0);
    add_row(0, 8'h60, 10, 0, 0,  1);
    add_row(0, 8'h00, 4,  1, 0,  1);
    add_row(0, 8'h4A, 7,  0, 0,  1);
  endtask

  // updatefc only after a stored posted or non-posted tlp
  task automatic expect_update_fc(input logic [7:0] fmt, input int len);
    data_cred_t inc;
    inc = data_cred_t'((len - `DL_HDR_DW + 3) / 4);
    if (fmt == 8'h40 || fmt == 8'h60) begin
      p_hdr = p_hdr + hdr_cred_t'(1);
      p_data = p_data + inc;
      want_dllp_q.push_back({`DL_DLLP_FC_P, 2'b00, p_hdr, 2'b00, p_data});
    end else if (fmt != 8'h0A && fmt != 8'h4A) begin
      np_hdr = np_hdr + hdr_cred_t'(1);
      np_data = np_data + inc;
      want_dllp_q.push_back({`DL_DLLP_FC_NP, 2'b00, np_hdr, 2'b00, np_data});
    end
  endtask

  task automatic make_frame(input int r);
    seq_num_t   seq;
    seq_num_t   prev;
    dl_word_t   crc;
    dl_word_t   w;
    logic [7:0] fmt;
    int         len;
    len = row_len[r];
    fmt = row_fmt[r][7:0];
    seq = exp_seq - seq_num_t'(row_back[r]);
    prev = exp_seq - seq_num_t'(1);
    frame_q.delete();
    frame_q.push_back(dl_word_t'(seq));
    crc = crc_word(32'hFFFF_FFFF, dl_word_t'(seq));
    for (int i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      w = (i == 0) ? {fmt, rng[23:0]} : rng;
      frame_q.push_back(w);
      crc = crc_word(crc, w);
    end
    crc = ~crc;
    if (row_bad[r] != 0) begin
      crc = crc ^ 32'h0000_0100;
    end
    frame_q.push_back(crc);
    if (row_bad[r] != 0) begin
      want_dllp_q.push_back({`DL_DLLP_NAK, 12'h000, prev});
    end else if (row_back[r] != 0) begin
      want_dllp_q.push_back({`DL_DLLP_ACK, 12'h000, prev});
    end else begin
      for (int i = 1; i <= len; i++) begin
        want_tlp_q.push_back(frame_q[i]);
        want_last_q.push_back(i == len);
      end
      want_dllp_q.push_back({`DL_DLLP_ACK, 12'h000, seq});
      exp_seq = exp_seq + seq_num_t'(1);
      expect_update_fc(fmt, len);
    end
  endtask

  // one clock, with the output ready lines updated on the edge
  task automatic next_cycle();
    @(posedge clk_i);
    if (tlp_hold > 0) begin
      tlp_ready_i <= 1'b0;
      tlp_hold = tlp_hold - 1;
    end else begin
      tlp_ready_i <= 1'b1;
    end
    if (dllp_jitter) begin
      rng = xorshift32(rng);
      dllp_ready_i <= rng[0];
    end else begin
      dllp_ready_i <= 1'b1;
    end
  endtask

  // returns once the word will be taken on the coming edge
  task automatic send_word(input dl_word_t w, input logic last);
    next_cycle();
    rx_valid_i <= 1'b1;
    rx_data_i <= w;
    rx_last_i <= last;
    @(negedge clk_i);
    while (!rx_ready_o) begin
      next_cycle();
      @(negedge clk_i);
    end
  endtask

  task automatic check_tlp_word(input dl_word_t got, input logic got_last);
    dl_word_t want;
    logic     want_last;
    if (want_tlp_q.size() == 0) begin
      report_failure("a TLP word came out while no stored TLP was pending");
    end else begin
      want = want_tlp_q.pop_front();
      want_last = want_last_q.pop_front();
      if (got !== want) begin
        report_failure($sformatf("[FAIL] tlp_data_o got %h expected %h", got, want));
      end else if (got_last !== want_last) begin
        report_failure($sformatf("[FAIL] tlp_last_o got %h expected %h", got_last, want_last));
      end
    end
  endtask

  task automatic check_dllp(input dl_word_t got);
    dl_word_t want;
    if (want_dllp_q.size() == 0) begin
      report_failure("a DLLP came out while none was expected");
    end else begin
      want = want_dllp_q.pop_front();
      if (got !== want) begin
        report_failure($sformatf("[FAIL] dllp_data_o got %h expected %h", got, want));
      end
    end
  endtask

  // a word moves on the edge after a negedge with valid and ready high
  always @(negedge clk_i) begin
    if (!rst_i && tlp_valid_o && tlp_ready_i) begin
      check_tlp_word(tlp_data_o, tlp_last_o);
    end
    if (!rst_i && dllp_valid_o && dllp_ready_i) begin
      check_dllp(dllp_data_o);
    end
  end

  initial begin : watchdog
    @(negedge rst_i);
    repeat (wd_cycles) @(posedge clk_i);
    report_failure("timeout: the DUT stopped answering frames");
  end

  initial begin : stimulus
    int total;
    clk_i = 1'b0;
    rst_i = 1'b1;
    rx_data_i = '0;
    rx_valid_i = 1'b0;
    rx_last_i = 1'b0;
    tlp_ready_i = 1'b0;
    dllp_ready_i = 1'b0;
    rng = 32'h9f2539c5;
    tlp_hold = 0;
    dllp_jitter = 1'b0;
    exp_seq = '0;
    p_hdr = '0;
    np_hdr = '0;
    p_data = '0;
    np_data = '0;
    build_table();
    total = 0;
    foreach (row_len[r]) begin
      total = total + row_len[r] + 2;
    end
    wd_cycles = total * 40 + 1000;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int r = 0; r < row_len.size(); r++) begin
      tlp_hold = row_hold[r];
      dllp_jitter = (row_jit[r] != 0);
      make_frame(r);
      for (int w = 0; w < frame_q.size(); w++) begin
        send_word(frame_q[w], w == frame_q.size() - 1);
      end
      next_cycle();
      rx_valid_i <= 1'b0;
      rx_last_i <= 1'b0;
    end

    // drain, then look for stray output
    while (want_tlp_q.size() != 0 || want_dllp_q.size() != 0) begin
      next_cycle();
    end
    repeat (20) next_cycle();
    if (!tlp_valid_o && !dllp_valid_o) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_failure("outputs still active after every frame was answered");
    end
  end

endmodule

// File: verilog.f
+incdir+logic
logic/dl_rx_pkg.sv
logic/lcrc_accum.sv
logic/dl_rx_frame.sv
logic/tlp_slot_buffer.sv
logic/tlp_out_stream.sv
logic/dllp_tx_gen.sv
logic/dl_rx_top.sv
verification/dl_rx_tb.sv
